/* source/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define DATA_W      8
`define REG_COUNT   8
`define DMEM_DEPTH  256
`define PMEM_DEPTH  256

// Opcodes in bits 8..6, 000 is NOP
`define OP_LDI   3'b001
`define OP_LDR   3'b010
`define OP_STI   3'b011
`define OP_STR   3'b100
`define OP_MOV   3'b101
`define OP_MATH  3'b110
`define OP_JMP   3'b111

// Write-back source
`define SEL_PC    3'b000
`define SEL_MEM   3'b001
`define SEL_IMM   3'b010
`define SEL_ALU   3'b011
`define SEL_REG   3'b100
`define SEL_NONE  3'b111

`endif

/* source/cpuPkg.sv */
`include "cpu_defs.svh"

package cpuPkg;

    typedef logic [`DATA_W-1:0] word_t;     // Data or data address
    typedef logic [2:0]         regIdx_t;
    typedef logic [8:0]         instr_t;

    // Bit 3 set means the ALU result is in use and flags update
    typedef logic [3:0]         aluOp_t;

    // Bit 3 set means a jump instruction is active
    typedef logic [3:0]         cond_t;

    typedef logic [2:0]         wbSel_t;

    // 00 none, 01 indirect read, 10 store immediate, 11 store register
    typedef logic [1:0]         memCtl_t;

    typedef logic [`DATA_W-1:0] pcAddr_t;

endpackage

/* source/controlUnit.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module controlUnit (
    input  cpuPkg::instr_t  i_instr,
    output logic            o_regWe,
    output cpuPkg::regIdx_t o_regDst,
    output cpuPkg::wbSel_t  o_wbSel,
    output cpuPkg::regIdx_t o_imm,
    output cpuPkg::cond_t   o_cond,
    output cpuPkg::aluOp_t  o_aluOp,
    output cpuPkg::memCtl_t o_memCtl,
    output cpuPkg::regIdx_t o_regX,
    output cpuPkg::regIdx_t o_regY
);
    import cpuPkg::*;

    logic [2:0] opcode;
    regIdx_t    fieldHi;    // Bits 5..3
    regIdx_t    fieldLo;    // Bits 2..0

    assign opcode  = i_instr[8:6];
    assign fieldHi = i_instr[5:3];
    assign fieldLo = i_instr[2:0];

    always_comb begin
        o_regWe  = 1'b0;
        o_regDst = '0;
        o_wbSel  = `SEL_NONE;
        o_imm    = '0;
        o_cond   = '0;
        o_aluOp  = '0;
        o_memCtl = 2'b00;
        o_regX   = '0;
        o_regY   = '0;
        case (opcode)
            `OP_LDI: begin
                o_regWe  = 1'b1;
                o_regDst = fieldHi;
                o_wbSel  = `SEL_IMM;
                o_imm    = fieldLo;
            end
            `OP_LDR: begin
                o_regWe  = 1'b1;
                o_regDst = fieldHi;
                o_wbSel  = `SEL_MEM;
                o_memCtl = 2'b01;
                o_regY   = fieldLo;       // Address register
            end
            `OP_STI: begin
                o_memCtl = 2'b10;
                o_imm    = fieldLo;
                o_regX   = fieldHi;
            end
            `OP_STR: begin
                o_memCtl = 2'b11;
                o_regX   = fieldHi;
                o_regY   = fieldLo;
            end
            `OP_MOV: begin
                o_regWe  = 1'b1;
                o_regDst = fieldHi;
                o_wbSel  = `SEL_REG;
                o_regY   = fieldLo;
            end
            `OP_MATH: begin
                o_regWe  = 1'b1;          // Result always to R0
                o_wbSel  = `SEL_ALU;
                o_aluOp  = {1'b1, fieldLo};
                o_regX   = fieldHi;
            end
            `OP_JMP: begin
                o_regDst = regIdx_t'(`REG_COUNT - 1);
                o_cond   = {1'b1, fieldLo};
                o_regX   = fieldHi;       // Target register
                if (fieldLo == 3'b001) begin
                    o_regWe = 1'b1;       // Call links into R7
                    o_wbSel = `SEL_PC;
                end
            end
            default: begin
                o_regWe = 1'b0;           // NOP
                o_wbSel = `SEL_NONE;
            end
        endcase
    end

    // A register write and a store never come from the same instruction
    always_comb begin
        assert (!(o_regWe && o_memCtl[1]))
            else $error("controlUnit: register write during store, instr %h", i_instr);
    end

endmodule

/* source/registerBank.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module registerBank (
    input  logic            i_clk,
    input  logic            i_arstN,
    input  logic            i_we,
    input  cpuPkg::regIdx_t i_dst,
    input  cpuPkg::regIdx_t i_idxX,
    input  cpuPkg::regIdx_t i_idxY,
    input  cpuPkg::wbSel_t  i_wbSel,
    input  cpuPkg::regIdx_t i_imm,
    input  cpuPkg::pcAddr_t i_pcNext,
    input  cpuPkg::word_t   i_memData,
    input  cpuPkg::word_t   i_aluResult,
    output cpuPkg::word_t   o_valX,
    output cpuPkg::word_t   o_valY,
    output cpuPkg::word_t   o_valR0,
    output cpuPkg::word_t   o_wrData
);
    import cpuPkg::*;

    word_t regs [`REG_COUNT];

    assign o_valX  = regs[i_idxX];
    assign o_valY  = regs[i_idxY];
    assign o_valR0 = regs[0];

    always_comb begin
        case (i_wbSel)
            `SEL_PC:  o_wrData = word_t'(i_pcNext);    // Return address
            `SEL_MEM: o_wrData = i_memData;
            `SEL_IMM: o_wrData = word_t'(i_imm);       // Zero extended
            `SEL_ALU: o_wrData = i_aluResult;
            `SEL_REG: o_wrData = o_valY;
            default:  o_wrData = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_dst] <= o_wrData;
        end
    end

    assert property (@(posedge i_clk) disable iff (!i_arstN)
        i_we |-> (i_wbSel != `SEL_NONE))
        else $error("registerBank: write to R%0d without a source", i_dst);

endmodule

/* source/alu.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module alu (
    input  logic           i_clk,
    input  logic           i_arstN,
    input  cpuPkg::aluOp_t i_op,
    input  cpuPkg::word_t  i_a,
    input  cpuPkg::word_t  i_b,
    output cpuPkg::word_t  o_result,
    output logic           o_zero,
    output logic           o_carry
);

    logic [`DATA_W:0] wide;    // Top bit is carry or borrow

    always_comb begin
        case (i_op[2:0])
            3'b000:  wide = {1'b0, i_a} + {1'b0, i_b};
            3'b001:  wide = {1'b0, i_a} - {1'b0, i_b};   // Borrow when a < b
            3'b010:  wide = {1'b0, i_a & i_b};
            3'b011:  wide = {1'b0, i_a | i_b};
            3'b100:  wide = {1'b0, i_a ^ i_b};
            3'b101:  wide = {i_a, 1'b0};                 // MSB out to carry
            3'b110:  wide = {i_a[0], 1'b0, i_a[`DATA_W-1:1]};
            default: wide = {1'b0, ~i_a};
        endcase
    end

    assign o_result = wide[`DATA_W-1:0];

    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            o_zero  <= 1'b0;
            o_carry <= 1'b0;
        end else if (i_op[3]) begin    // Only on MATH
            o_zero  <= (o_result == '0);
            o_carry <= wide[`DATA_W];
        end
    end

endmodule

/* source/instructionFetch.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module instructionFetch (
    input  logic            i_clk,
    input  logic            i_arstN,
    input  logic            i_run,
    input  logic            i_progWe,
    input  cpuPkg::pcAddr_t i_progAddr,
    input  cpuPkg::instr_t  i_progData,
    input  cpuPkg::cond_t   i_cond,
    input  cpuPkg::word_t   i_target,
    input  logic            i_zero,
    input  logic            i_carry,
    output cpuPkg::instr_t  o_instr,
    output cpuPkg::pcAddr_t o_pc,
    output cpuPkg::pcAddr_t o_pcNext
);
    import cpuPkg::*;

    instr_t pmem [`PMEM_DEPTH];
    logic   condMet;
    logic   jumpTaken;

    always_ff @(posedge i_clk) begin
        if (i_progWe && !i_run) begin
            pmem[i_progAddr] <= i_progData;
        end
    end

    assign o_instr  = i_run ? pmem[o_pc] : '0;    // NOP while stopped
    assign o_pcNext = o_pc + 1'b1;                // Wraps at 256

    always_comb begin
        case (i_cond[2:0])
            3'b000, 3'b001: condMet = 1'b1;       // Jump and call
            3'b010:         condMet = i_zero;
            3'b011:         condMet = !i_zero;
            3'b100:         condMet = i_carry;
            3'b101:         condMet = !i_carry;
            default:        condMet = 1'b0;
        endcase
    end

    assign jumpTaken = i_cond[3] && condMet;

    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            o_pc <= '0;
        end else if (i_run) begin
            o_pc <= jumpTaken ? pcAddr_t'(i_target) : o_pcNext;
        end
    end

    // Program loads only happen while the core is stopped
    assert property (@(posedge i_clk) disable iff (!i_arstN)
        !(i_progWe && i_run))
        else $error("instructionFetch: program write at %h while running", i_progAddr);

endmodule

/* source/dataMemory.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module dataMemory (
    input  logic            i_clk,
    input  cpuPkg::memCtl_t i_ctl,
    input  cpuPkg::word_t   i_addrX,
    input  cpuPkg::word_t   i_addrY,
    input  cpuPkg::regIdx_t i_imm,
    input  cpuPkg::word_t   i_valY,
    output cpuPkg::word_t   o_rdData,
    output logic            o_we,
    output cpuPkg::word_t   o_addr,
    output cpuPkg::word_t   o_wrData
);
    import cpuPkg::*;

    word_t mem [`DMEM_DEPTH];

    assign o_we     = i_ctl[1];                          // Both store codes
    assign o_addr   = (i_ctl == 2'b01) ? i_addrY : i_addrX;
    assign o_wrData = (i_ctl == 2'b10) ? word_t'(i_imm) : i_valY;
    assign o_rdData = mem[o_addr];

    always_ff @(posedge i_clk) begin
        if (o_we) begin
            mem[o_addr] <= o_wrData;
        end
    end

endmodule

/* source/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop (
    input  logic            i_clk,
    input  logic            i_arstN,
    input  logic            i_run,
    input  logic            i_progWe,
    input  cpuPkg::pcAddr_t i_progAddr,
    input  cpuPkg::instr_t  i_progData,
    output cpuPkg::pcAddr_t o_pc,
    output logic            o_regWe,
    output cpuPkg::regIdx_t o_regIdx,
    output cpuPkg::word_t   o_regData,
    output logic            o_memWe,
    output cpuPkg::word_t   o_memAddr,
    output cpuPkg::word_t   o_memData
);
    import cpuPkg::*;

    instr_t  instr;
    pcAddr_t pcNext;
    wbSel_t  wbSel;
    regIdx_t imm;
    regIdx_t regX;
    regIdx_t regY;
    cond_t   cond;
    aluOp_t  aluOp;
    memCtl_t memCtl;
    word_t   valX;
    word_t   valY;
    word_t   valR0;
    word_t   aluResult;
    word_t   memRdData;
    logic    zeroFlag;
    logic    carryFlag;

    instructionFetch u_fetch (
        .i_clk      (i_clk),
        .i_arstN    (i_arstN),
        .i_run      (i_run),
        .i_progWe   (i_progWe),
        .i_progAddr (i_progAddr),
        .i_progData (i_progData),
        .i_cond     (cond),
        .i_target   (valX),          // Jump target is RX
        .i_zero     (zeroFlag),
        .i_carry    (carryFlag),
        .o_instr    (instr),
        .o_pc       (o_pc),
        .o_pcNext   (pcNext)
    );

    controlUnit u_ctrl (
        .i_instr  (instr),
        .o_regWe  (o_regWe),
        .o_regDst (o_regIdx),
        .o_wbSel  (wbSel),
        .o_imm    (imm),
        .o_cond   (cond),
        .o_aluOp  (aluOp),
        .o_memCtl (memCtl),
        .o_regX   (regX),
        .o_regY   (regY)
    );

    registerBank u_regs (
        .i_clk       (i_clk),
        .i_arstN     (i_arstN),
        .i_we        (o_regWe),
        .i_dst       (o_regIdx),
        .i_idxX      (regX),
        .i_idxY      (regY),
        .i_wbSel     (wbSel),
        .i_imm       (imm),
        .i_pcNext    (pcNext),
        .i_memData   (memRdData),
        .i_aluResult (aluResult),
        .o_valX      (valX),
        .o_valY      (valY),
        .o_valR0     (valR0),
        .o_wrData    (o_regData)
    );

    alu u_alu (
        .i_clk    (i_clk),
        .i_arstN  (i_arstN),
        .i_op     (aluOp),
        .i_a      (valR0),           // R0 op RX
        .i_b      (valX),
        .o_result (aluResult),
        .o_zero   (zeroFlag),
        .o_carry  (carryFlag)
    );

    dataMemory u_dmem (
        .i_clk    (i_clk),
        .i_ctl    (memCtl),
        .i_addrX  (valX),
        .i_addrY  (valY),
        .i_imm    (imm),
        .i_valY   (valY),
        .o_rdData (memRdData),
        .o_we     (o_memWe),
        .o_addr   (o_memAddr),
        .o_wrData (o_memData)
    );

endmodule

/* verification/isaModel.svh */
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// Architectural state, stepped once per executed instruction
word_t       mRegs [8];
word_t       mMem [256];
instr_t      mPmem [256];
pcAddr_t     mPc;
logic        mZero;
logic        mCarry;
logic [31:0] rngState = 32'h9c3ab2d9;

function automatic logic [31:0] nextRand();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
endfunction

task automatic resetModel();
    foreach (mRegs[i]) mRegs[i] = '0;
    mPc    = '0;
    mZero  = 1'b0;
    mCarry = 1'b0;
endtask

task automatic aluModel(input logic [2:0] op, input word_t a, input word_t b,
                        output word_t res, output logic cy);
    int sum;
    sum = int'(a) + int'(b);
    cy  = 1'b0;    // Logic ops and invert
    case (op)
        3'd0: begin res = word_t'(sum); cy = (sum > 255); end
        3'd1: begin res = a - b; cy = (a < b); end
        3'd2: res = a & b;
        3'd3: res = a | b;
        3'd4: res = a ^ b;
        3'd5: begin res = a << 1; cy = a[7]; end
        3'd6: begin res = a >> 1; cy = a[0]; end
        default: res = ~a;
    endcase
endtask

function automatic logic conditionMet(input logic [2:0] cond);
    case (cond)
        3'd2:    return mZero;
        3'd3:    return !mZero;
        3'd4:    return mCarry;
        3'd5:    return !mCarry;
        3'd6,
        3'd7:    return 1'b0;
        default: return 1'b1;    // Jump and call
    endcase
endfunction

// Expected observation outputs for the instruction at mPc
task automatic predictOutputs(output logic we, output regIdx_t idx, output word_t data,
                              output logic memWe, output word_t addr, output word_t memData);
    instr_t  ins;
    regIdx_t hi;
    regIdx_t lo;
    logic    cy;
    ins = mPmem[mPc];
    hi  = ins[5:3];
    lo  = ins[2:0];
    {we, idx, data, memWe, addr, memData} = '0;
    case (ins[8:6])
        `OP_LDI:  begin we = 1'b1; idx = hi; data = word_t'(lo); end
        `OP_LDR:  begin we = 1'b1; idx = hi; data = mMem[mRegs[lo]]; end
        `OP_STI:  begin memWe = 1'b1; addr = mRegs[hi]; memData = word_t'(lo); end
        `OP_STR:  begin memWe = 1'b1; addr = mRegs[hi]; memData = mRegs[lo]; end
        `OP_MOV:  begin we = 1'b1; idx = hi; data = mRegs[lo]; end
        `OP_MATH: begin we = 1'b1; aluModel(lo, mRegs[0], mRegs[hi], data, cy); end
        `OP_JMP:  if (lo == 3'd1) begin we = 1'b1; idx = 3'd7; data = mPc + 8'd1; end
        default:  ;
    endcase
endtask

task automatic stepModel();
    logic    we;
    logic    memWe;
    logic    cy;
    regIdx_t idx;
    word_t   data;
    word_t   addr;
    word_t   memData;
    word_t   res;
    pcAddr_t nextPc;
    instr_t  ins;
    ins = mPmem[mPc];
    predictOutputs(we, idx, data, memWe, addr, memData);
    nextPc = mPc + 8'd1;
    if (ins[8:6] == `OP_JMP && conditionMet(ins[2:0])) nextPc = mRegs[ins[5:3]];  // Old RX
    if (ins[8:6] == `OP_MATH) begin
        aluModel(ins[2:0], mRegs[0], mRegs[ins[5:3]], res, cy);
        mZero  = (res == 8'h00);
        mCarry = cy;
    end
    if (we) mRegs[idx] = data;
    if (memWe) mMem[addr] = memData;
    mPc = nextPc;
endtask

`endif

/* verification/cpuTb.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpuTb;
    import cpuPkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_PROG     = 32;
    localparam int NUM_PROGS    = 36;    // Reset test plus every loaded program
    localparam int WATCHDOG_NS  =
        (NUM_PROGS * (RESET_CYCLES + 3 * MAX_PROG + 4) + 100) * CLK_PERIOD;

    logic    i_clk;
    logic    i_arstN;
    logic    i_run;
    logic    i_progWe;
    pcAddr_t i_progAddr;
    instr_t  i_progData;
    pcAddr_t o_pc;
    logic    o_regWe;
    regIdx_t o_regIdx;
    word_t   o_regData;
    logic    o_memWe;
    word_t   o_memAddr;
    word_t   o_memData;

    instr_t prog [$];
    int     errCount   = 0;
    int     checkCount = 0;
    int     testCount  = 0;

    `include "isaModel.svh"

    cpuTop UUT (.*);

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Finished with errors");
        $finish;
    end

    function automatic instr_t encode(input logic [2:0] op, input regIdx_t hi, input regIdx_t lo);
        return {op, hi, lo};
    endfunction

    task automatic checkSignal(input string name, input word_t got, input word_t exp);
        checkCount++;
        assert (got === exp) else begin
            $display("Error %s: expected %h, got %h", name, exp, got);
            errCount++;
        end
    endtask

    task automatic reportTest(input string name, input int errsBefore);
        testCount++;
        if (errCount == errsBefore) $display("Test %s passed", name);
        else $display("Test %s failed with %0d errors", name, errCount - errsBefore);
    endtask

    task automatic applyReset();
        @(negedge i_clk);
        i_arstN = 1'b0;
        repeat (RESET_CYCLES) @(negedge i_clk);
        i_arstN = 1'b1;
        resetModel();
    endtask

    task automatic checkCycle();
        logic    expWe;
        logic    expMemWe;
        regIdx_t expIdx;
        word_t   expData;
        word_t   expAddr;
        word_t   expMemData;
        predictOutputs(expWe, expIdx, expData, expMemWe, expAddr, expMemData);
        checkSignal("o_pc", o_pc, mPc);
        checkSignal("o_regWe", 8'(o_regWe), 8'(expWe));
        checkSignal("o_memWe", 8'(o_memWe), 8'(expMemWe));
        if (expWe) begin
            checkSignal("o_regIdx", 8'(o_regIdx), 8'(expIdx));
            checkSignal("o_regData", o_regData, expData);
        end
        if (expMemWe) begin
            checkSignal("o_memAddr", o_memAddr, expAddr);
            checkSignal("o_memData", o_memData, expMemData);
        end
    endtask

    // Reset, load prog from address 0, run until the model leaves its last word
    task automatic executeProgram();
        int cycles;
        cycles = 0;
        applyReset();
        foreach (prog[i]) begin
            @(negedge i_clk);
            i_progWe   = 1'b1;
            i_progAddr = pcAddr_t'(i);
            i_progData = prog[i];
            mPmem[i]   = prog[i];
        end
        @(negedge i_clk);
        i_progWe = 1'b0;
        i_run    = 1'b1;
        while (mPc != pcAddr_t'(prog.size()) && cycles < 2 * MAX_PROG) begin
            #(CLK_PERIOD / 4);    // Outputs settled
            checkCycle();
            @(posedge i_clk);
            stepModel();
            @(negedge i_clk);
            cycles++;
        end
        checkSignal("o_pc", o_pc, mPc);    // PC after the last instruction
        i_run = 1'b0;
        if (mPc != pcAddr_t'(prog.size())) begin
            $display("Program of %0d words did not reach its end", prog.size());
            errCount++;
        end
    endtask

    task automatic testReset();
        int errsBefore;
        errsBefore = errCount;
        applyReset();
        repeat (4) begin
            @(negedge i_clk);
            #(CLK_PERIOD / 4);
            checkSignal("o_pc", o_pc, 8'h00);
            checkSignal("o_regWe", 8'(o_regWe), 8'h00);
            checkSignal("o_memWe", 8'(o_memWe), 8'h00);
        end
        reportTest("reset", errsBefore);
    endtask

    task automatic testLoadMove();
        int errsBefore;
        errsBefore = errCount;
        prog.delete();
        for (int i = 0; i < 8; i++) prog.push_back(encode(`OP_LDI, 3'(i), 3'(nextRand())));
        for (int i = 0; i < 8; i++) prog.push_back(encode(`OP_MOV, 3'(i), 3'((i + 3) % 8)));
        executeProgram();
        reportTest("load and move", errsBefore);
    endtask

    task automatic testMath();
        int   errsBefore;
        logic inv;
        errsBefore = errCount;
        for (int op = 0; op < 8; op++) begin
            for (int flag = 0; flag < 2; flag++) begin
                inv = nextRand() & 1;    // Inverted R0 gives large operands
                prog.delete();
                prog.push_back(encode(`OP_LDI, 3'd2, inv ? 3'd7 : 3'd6));
                prog.push_back(encode(`OP_LDI, 3'd0, 3'(nextRand())));
                if (inv) prog.push_back(encode(`OP_MATH, 3'd0, 3'b111));
                prog.push_back(encode(`OP_LDI, 3'd1, 3'(nextRand())));
                prog.push_back(encode(`OP_MATH, 3'd1, 3'(op)));
                prog.push_back(encode(`OP_JMP, 3'd2, flag ? 3'b100 : 3'b010));  // Carry or zero
                prog.push_back(encode(`OP_LDI, 3'd3, 3'd1));
                executeProgram();
            end
        end
        reportTest("math", errsBefore);
    endtask

    task automatic testMemory();
        int      errsBefore;
        regIdx_t addrA;
        errsBefore = errCount;
        prog.delete();
        for (int r = 0; r < 4; r++) begin
            addrA = 3'(nextRand());
            prog.push_back(encode(`OP_LDI, 3'd1, addrA));
            prog.push_back(encode(`OP_STI, 3'd1, 3'(nextRand())));
            prog.push_back(encode(`OP_LDI, 3'd2, addrA ^ 3'(1 + nextRand() % 7)));
            prog.push_back(encode(`OP_LDI, 3'd3, 3'(nextRand())));
            prog.push_back(encode(`OP_STR, 3'd2, 3'd3));
            prog.push_back(encode(`OP_LDR, 3'd4, 3'd1));
            prog.push_back(encode(`OP_LDR, 3'd5, 3'd2));
        end
        executeProgram();
        reportTest("memory", errsBefore);
    endtask

    task automatic testJump();
        int errsBefore;
        errsBefore = errCount;
        for (int c = 0; c < 8; c++) begin
            for (int s = 0; s < 2; s++) begin
                prog.delete();
                prog.push_back(encode(`OP_LDI, 3'd0, s ? 3'd5 : 3'd3));  // Zero or borrow
                prog.push_back(encode(`OP_LDI, 3'd2, 3'd5));
                prog.push_back(encode(`OP_MATH, 3'd2, 3'b001));
                prog.push_back(encode(`OP_LDI, 3'd1, 3'd6));
                prog.push_back(encode(`OP_JMP, 3'd1, 3'(c)));
                prog.push_back(encode(`OP_LDI, 3'd3, 3'd1));
                prog.push_back(encode(`OP_MOV, 3'd4, 3'd7));    // Shows the link
                executeProgram();
            end
        end
        reportTest("jump", errsBefore);
    endtask

    task automatic testNop();
        int errsBefore;
        errsBefore = errCount;
        prog.delete();
        for (int i = 0; i < 6; i++) begin
            prog.push_back(encode(`OP_LDI, 3'(i), 3'(nextRand())));
            prog.push_back(encode(3'b000, 3'(nextRand()), 3'(nextRand())));
        end
        executeProgram();
        reportTest("nop", errsBefore);
    endtask

    initial begin
        i_arstN    = 1'b0;
        i_run      = 1'b0;
        i_progWe   = 1'b0;
        i_progAddr = '0;
        i_progData = '0;
        testReset();
        testLoadMove();
        testMath();
        testMemory();
        testJump();
        testNop();
        $display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
        if (errCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+source
+incdir+verification
source/cpuPkg.sv
source/controlUnit.sv
source/registerBank.sv
source/alu.sv
source/instructionFetch.sv
source/dataMemory.sv
source/cpuTop.sv
verification/cpuTb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = cpuTb
FILELIST = tb.f
BUILDDIR = obj_dir
LOG      = sim.log
PASS_MSG = Finished with no errors

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)
